// File: Makefile
SIM      ?= verilator
TOP      ?= tb_spu_issue
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert --timescale 1ns/10ps -j 0
FILELIST ?= build.f

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
spu_isa_pkg.sv
spu_pipe_pkg.sv
instr_decode.sv
hazard_unit.sv
issue_ctrl.sv
exec_pipe.sv
spu_issue_top.sv
spu_issue_checker.sv
tb_spu_issue.sv

// File: exec_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module exec_pipe #(
  parameter int pipe_depth = 6
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      issue,
  input  logic [spu_isa_pkg::reg_addr_w-1:0]        dest,
  input  logic                                      dest_valid,
  input  logic [spu_isa_pkg::lat_w-1:0]             lat,
  output logic [pipe_depth*spu_pipe_pkg::rec_w-1:0] stage_recs,
  output logic                                      wb_valid,
  output logic [spu_isa_pkg::reg_addr_w-1:0]        wb_dest
);

  localparam int rec_w = spu_pipe_pkg::rec_w;

  logic                                valid_q [1:pipe_depth];
  logic [spu_pipe_pkg::rec_dest_w-1:0] dest_q  [1:pipe_depth];
  logic [spu_pipe_pkg::rec_lat_w-1:0]  lat_q   [1:pipe_depth];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 1; k <= pipe_depth; k++) begin
        valid_q[k] <= 1'b0;
      end
    end else begin
      valid_q[1] <= issue && dest_valid; // Bubble when nothing writes
      for (int k = 2; k <= pipe_depth; k++) begin
        valid_q[k] <= valid_q[k-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    dest_q[1] <= dest;
    lat_q[1]  <= lat;
    for (int k = 2; k <= pipe_depth; k++) begin
      dest_q[k] <= dest_q[k-1];
      lat_q[k]  <= lat_q[k-1];
    end
  end

  always_comb begin
    for (int k = 1; k <= pipe_depth; k++) begin
      stage_recs[(k-1)*rec_w +: rec_w] = {valid_q[k], dest_q[k], lat_q[k]};
    end
  end

  // Deeper stage wins if two records finish together
  always_comb begin
    wb_valid = 1'b0;
    wb_dest  = '0;
    for (int k = 1; k <= pipe_depth; k++) begin
      if (valid_q[k] && int'(lat_q[k]) == k) begin
        wb_valid = 1'b1;
        wb_dest  = dest_q[k];
      end
    end
  end

endmodule

`default_nettype wire

// File: hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit #(
  parameter int pipe_depth = 6
) (
  input  spu_isa_pkg::pipe_e                            pipe0,
  input  logic [spu_isa_pkg::reg_addr_w-1:0]            ra0,
  input  logic [spu_isa_pkg::reg_addr_w-1:0]            rb0,
  input  logic [spu_isa_pkg::reg_addr_w-1:0]            rc0,
  input  logic                                          ra_use0,
  input  logic                                          rb_use0,
  input  logic                                          rc_use0,
  input  logic [spu_isa_pkg::reg_addr_w-1:0]            dest0,
  input  logic                                          dest_valid0,
  input  spu_isa_pkg::pipe_e                            pipe1,
  input  logic [spu_isa_pkg::reg_addr_w-1:0]            ra1,
  input  logic [spu_isa_pkg::reg_addr_w-1:0]            rb1,
  input  logic [spu_isa_pkg::reg_addr_w-1:0]            rc1,
  input  logic                                          ra_use1,
  input  logic                                          rb_use1,
  input  logic                                          rc_use1,
  input  logic [spu_isa_pkg::reg_addr_w-1:0]            dest1,
  input  logic                                          dest_valid1,
  input  logic [pipe_depth*spu_pipe_pkg::rec_w-1:0]     stage_recs_even,
  input  logic [pipe_depth*spu_pipe_pkg::rec_w-1:0]     stage_recs_odd,
  output logic                                          raw0,
  output logic                                          raw1,
  output logic                                          pair_conflict
);

  localparam int rec_w = spu_pipe_pkg::rec_w;
  localparam int aw    = spu_isa_pkg::reg_addr_w;

  logic [rec_w-1:0] rec_even;
  logic [rec_w-1:0] rec_odd;
  logic             active0;
  logic             active1;
  logic             dep10;

  // True when a source still waits on the record's result
  function automatic logic rec_blocks(input logic [rec_w-1:0] rec, input int stage,
                                      input logic [aw-1:0] a, input logic a_used,
                                      input logic [aw-1:0] b, input logic b_used,
                                      input logic [aw-1:0] c, input logic c_used);
    logic [aw-1:0]                 rec_dest;
    logic [spu_isa_pkg::lat_w-1:0] rec_lat;
    logic                          hit;
    rec_dest = rec[spu_pipe_pkg::rec_dest_msb:spu_pipe_pkg::rec_dest_lsb];
    rec_lat  = rec[spu_pipe_pkg::rec_lat_msb:spu_pipe_pkg::rec_lat_lsb];
    hit = (a_used && a == rec_dest) || (b_used && b == rec_dest) || (c_used && c == rec_dest);
    return rec[spu_pipe_pkg::rec_valid_bit] && hit && (int'(rec_lat) > stage + 1);
  endfunction

  assign active0 = (pipe0 != spu_isa_pkg::PIPE_NONE);
  assign active1 = (pipe1 != spu_isa_pkg::PIPE_NONE);

  always_comb begin
    raw0     = 1'b0;
    raw1     = 1'b0;
    rec_even = '0;
    rec_odd  = '0;
    for (int k = 1; k <= pipe_depth; k++) begin
      rec_even = stage_recs_even[(k-1)*rec_w +: rec_w];
      rec_odd  = stage_recs_odd[(k-1)*rec_w +: rec_w];
      raw0 = raw0 | rec_blocks(rec_even, k, ra0, ra_use0, rb0, rb_use0, rc0, rc_use0)
                  | rec_blocks(rec_odd, k, ra0, ra_use0, rb0, rb_use0, rc0, rc_use0);
      raw1 = raw1 | rec_blocks(rec_even, k, ra1, ra_use1, rb1, rb_use1, rc1, rc_use1)
                  | rec_blocks(rec_odd, k, ra1, ra_use1, rb1, rb_use1, rc1, rc_use1);
    end
    raw0 = raw0 & active0;
    raw1 = raw1 & active1;
  end

  // Slot 1 consumes what slot 0 produces
  assign dep10 = dest_valid0 && ((ra_use1 && ra1 == dest0) || (rb_use1 && rb1 == dest0) ||
                                 (rc_use1 && rc1 == dest0));

  assign pair_conflict = active0 && active1 &&
                         ((pipe0 == pipe1) || (dest_valid0 && dest_valid1 && dest0 == dest1) ||
                          dep10);

endmodule

`default_nettype wire

// File: instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
  input  logic [spu_isa_pkg::instr_w-1:0]    instr,
  output spu_isa_pkg::pipe_e                 pipe,
  output logic [spu_isa_pkg::reg_addr_w-1:0] ra,
  output logic [spu_isa_pkg::reg_addr_w-1:0] rb,
  output logic [spu_isa_pkg::reg_addr_w-1:0] rc,
  output logic                               ra_use,
  output logic                               rb_use,
  output logic                               rc_use,
  output logic [spu_isa_pkg::reg_addr_w-1:0] dest,
  output logic                               dest_valid,
  output logic [spu_isa_pkg::lat_w-1:0]      lat
);

  spu_isa_pkg::opcode_e op;

  assign op   = spu_isa_pkg::opcode_e'(instr[spu_isa_pkg::op_msb:spu_isa_pkg::op_lsb]);
  assign dest = instr[spu_isa_pkg::rt_msb:spu_isa_pkg::rt_lsb];
  assign ra   = instr[spu_isa_pkg::ra_msb:spu_isa_pkg::ra_lsb];
  assign rc   = instr[spu_isa_pkg::rc_msb:spu_isa_pkg::rc_lsb];
  assign lat  = spu_isa_pkg::op_latency(op);

  always_comb begin
    pipe       = spu_isa_pkg::PIPE_NONE;
    rb         = instr[spu_isa_pkg::rb_msb:spu_isa_pkg::rb_lsb];
    ra_use     = 1'b0;
    rb_use     = 1'b0;
    rc_use     = 1'b0;
    dest_valid = 1'b0;
    case (op)
      spu_isa_pkg::ADD, spu_isa_pkg::SHL, spu_isa_pkg::MPY: begin
        pipe       = spu_isa_pkg::PIPE_EVEN;
        ra_use     = 1'b1;
        rb_use     = 1'b1;
        dest_valid = 1'b1;
      end
      spu_isa_pkg::FMA, spu_isa_pkg::SHUF: begin
        pipe       = (op == spu_isa_pkg::FMA) ? spu_isa_pkg::PIPE_EVEN : spu_isa_pkg::PIPE_ODD;
        ra_use     = 1'b1;
        rb_use     = 1'b1;
        rc_use     = 1'b1;
        dest_valid = 1'b1;
      end
      spu_isa_pkg::LOAD: begin
        pipe       = spu_isa_pkg::PIPE_ODD;
        ra_use     = 1'b1;
        dest_valid = 1'b1;
      end
      spu_isa_pkg::STORE: begin
        pipe   = spu_isa_pkg::PIPE_ODD;
        rb     = instr[spu_isa_pkg::rt_msb:spu_isa_pkg::rt_lsb]; // Store data comes from rt
        ra_use = 1'b1;
        rb_use = 1'b1;
      end
      spu_isa_pkg::BR: begin
        pipe   = spu_isa_pkg::PIPE_ODD;
        ra_use = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: issue_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module issue_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               pair_valid,
  input  spu_isa_pkg::pipe_e pipe0,
  input  spu_isa_pkg::pipe_e pipe1,
  input  logic               raw0,
  input  logic               raw1,
  input  logic               pair_conflict,
  output logic               stall,
  output logic               issue_even,
  output logic               issue_odd,
  output logic               even_sel,
  output logic               odd_sel
);

  spu_pipe_pkg::issue_state_e state_q;
  spu_pipe_pkg::issue_state_e state_d;
  logic                       issue_slot0;
  logic                       issue_slot1;

  always_comb begin
    state_d     = state_q; // Held while fetch has no pair
    stall       = 1'b0;
    issue_slot0 = 1'b0;
    issue_slot1 = 1'b0;
    if (pair_valid) begin
      case (state_q)
        spu_pipe_pkg::ISSUE_PAIR: begin
          if (raw0) begin
            stall = 1'b1;
          end else if (pair_conflict || raw1) begin
            issue_slot0 = 1'b1;
            stall       = 1'b1;
            state_d     = spu_pipe_pkg::ISSUE_SECOND;
          end else begin
            issue_slot0 = 1'b1;
            issue_slot1 = 1'b1;
          end
        end
        spu_pipe_pkg::ISSUE_SECOND: begin
          if (raw1) begin
            stall = 1'b1;
          end else begin
            issue_slot1 = 1'b1;
            state_d     = spu_pipe_pkg::ISSUE_PAIR;
          end
        end
      endcase
    end
  end

  // A NOP slot issues silently, it has no pipe to strobe
  assign issue_even = (issue_slot0 && pipe0 == spu_isa_pkg::PIPE_EVEN) ||
                      (issue_slot1 && pipe1 == spu_isa_pkg::PIPE_EVEN);
  assign issue_odd  = (issue_slot0 && pipe0 == spu_isa_pkg::PIPE_ODD) ||
                      (issue_slot1 && pipe1 == spu_isa_pkg::PIPE_ODD);
  assign even_sel   = issue_slot1 && pipe1 == spu_isa_pkg::PIPE_EVEN; // High picks slot 1
  assign odd_sel    = issue_slot1 && pipe1 == spu_isa_pkg::PIPE_ODD;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= spu_pipe_pkg::ISSUE_PAIR;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: spu_isa_pkg.sv
`default_nettype none

package spu_isa_pkg;

  localparam int instr_w    = 32;
  localparam int opcode_w   = 4;
  localparam int reg_addr_w = 7;
  localparam int lat_w      = 3;

  // Word layout, opcode on top then rt, ra, rb, rc
  localparam int op_msb = 31;
  localparam int op_lsb = 28;
  localparam int rt_msb = 27;
  localparam int rt_lsb = 21;
  localparam int ra_msb = 20;
  localparam int ra_lsb = 14;
  localparam int rb_msb = 13;
  localparam int rb_lsb = 7;
  localparam int rc_msb = 6;
  localparam int rc_lsb = 0;

  typedef enum logic [opcode_w-1:0] {
    NOP   = 4'd0,
    ADD   = 4'd1,
    SHL   = 4'd2,
    MPY   = 4'd3,
    FMA   = 4'd4,
    LOAD  = 4'd5,
    SHUF  = 4'd6,
    STORE = 4'd7,
    BR    = 4'd8
  } opcode_e;

  typedef enum logic [1:0] {
    PIPE_NONE = 2'd0,
    PIPE_EVEN = 2'd1,
    PIPE_ODD  = 2'd2
  } pipe_e;

  localparam logic [lat_w-1:0] lat_none = 3'd0; // No result written
  localparam logic [lat_w-1:0] lat_add  = 3'd2;
  localparam logic [lat_w-1:0] lat_shl  = 3'd4;
  localparam logic [lat_w-1:0] lat_mpy  = 3'd6;
  localparam logic [lat_w-1:0] lat_fma  = 3'd6;
  localparam logic [lat_w-1:0] lat_load = 3'd6;
  localparam logic [lat_w-1:0] lat_shuf = 3'd4;

  function automatic logic [lat_w-1:0] op_latency(input opcode_e op);
    case (op)
      ADD:     return lat_add;
      SHL:     return lat_shl;
      MPY:     return lat_mpy;
      FMA:     return lat_fma;
      LOAD:    return lat_load;
      SHUF:    return lat_shuf;
      default: return lat_none; // NOP, STORE, BR and unused codes
    endcase
  endfunction

endpackage

`default_nettype wire

// File: spu_issue_checker.sv
`timescale 1ns/10ps
`default_nettype none

module spu_issue_checker (
  input logic clk,
  input logic rst,
  input logic pair_valid,
  input logic stall,
  input logic wb_valid_even,
  input logic wb_valid_odd
);

  logic any_wb;

  assign any_wb = wb_valid_even || wb_valid_odd;

  // Pipes come out of reset empty
  a_wb_after_reset: assert property (@(posedge clk) rst |=> !any_wb)
    else $error("writeback valid in the cycle after reset");

  // Shortest latency is 2, so the second edge after release stays quiet too
  a_wb_release_second: assert property (@(posedge clk) $fell(rst) |=> !any_wb)
    else $error("writeback on the second edge after reset release");

  a_stall_needs_pair: assert property (@(posedge clk) !pair_valid |-> !stall)
    else $error("stall raised while fetch offers no pair");

endmodule

bind spu_issue_top spu_issue_checker u_checker (
  .clk(clk),
  .rst(rst),
  .pair_valid(pair_valid),
  .stall(stall),
  .wb_valid_even(wb_valid_even),
  .wb_valid_odd(wb_valid_odd)
);

`default_nettype wire

// File: spu_issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module spu_issue_top #(
  parameter int pipe_depth = 6
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               pair_valid,
  input  logic [spu_isa_pkg::instr_w-1:0]    instr0,
  input  logic [spu_isa_pkg::instr_w-1:0]    instr1,
  output logic                               stall,
  output logic                               wb_valid_even,
  output logic [spu_isa_pkg::reg_addr_w-1:0] wb_dest_even,
  output logic                               wb_valid_odd,
  output logic [spu_isa_pkg::reg_addr_w-1:0] wb_dest_odd
);

  localparam int aw = spu_isa_pkg::reg_addr_w;
  localparam int lw = spu_isa_pkg::lat_w;

  spu_isa_pkg::pipe_e pipe0, pipe1;
  logic [aw-1:0] ra0, rb0, rc0, dest0;
  logic [aw-1:0] ra1, rb1, rc1, dest1;
  logic ra_use0, rb_use0, rc_use0, dest_valid0;
  logic ra_use1, rb_use1, rc_use1, dest_valid1;
  logic [lw-1:0] lat0, lat1;
  logic raw0, raw1, pair_conflict;
  logic issue_even, issue_odd, even_sel, odd_sel;
  logic [pipe_depth*spu_pipe_pkg::rec_w-1:0] stage_recs_even, stage_recs_odd;

  instr_decode u_dec0 (.instr(instr0), .pipe(pipe0), .ra(ra0), .rb(rb0), .rc(rc0),
                       .ra_use(ra_use0), .rb_use(rb_use0), .rc_use(rc_use0),
                       .dest(dest0), .dest_valid(dest_valid0), .lat(lat0));

  instr_decode u_dec1 (.instr(instr1), .pipe(pipe1), .ra(ra1), .rb(rb1), .rc(rc1),
                       .ra_use(ra_use1), .rb_use(rb_use1), .rc_use(rc_use1),
                       .dest(dest1), .dest_valid(dest_valid1), .lat(lat1));

  hazard_unit #(.pipe_depth(pipe_depth)) u_hazard (
    .pipe0(pipe0), .ra0(ra0), .rb0(rb0), .rc0(rc0),
    .ra_use0(ra_use0), .rb_use0(rb_use0), .rc_use0(rc_use0),
    .dest0(dest0), .dest_valid0(dest_valid0),
    .pipe1(pipe1), .ra1(ra1), .rb1(rb1), .rc1(rc1),
    .ra_use1(ra_use1), .rb_use1(rb_use1), .rc_use1(rc_use1),
    .dest1(dest1), .dest_valid1(dest_valid1),
    .stage_recs_even(stage_recs_even), .stage_recs_odd(stage_recs_odd),
    .raw0(raw0), .raw1(raw1), .pair_conflict(pair_conflict));

  issue_ctrl u_issue (.clk(clk), .rst(rst), .pair_valid(pair_valid),
                      .pipe0(pipe0), .pipe1(pipe1), .raw0(raw0), .raw1(raw1),
                      .pair_conflict(pair_conflict), .stall(stall),
                      .issue_even(issue_even), .issue_odd(issue_odd),
                      .even_sel(even_sel), .odd_sel(odd_sel));

  exec_pipe #(.pipe_depth(pipe_depth)) u_pipe_even (
    .clk(clk), .rst(rst), .issue(issue_even),
    .dest(even_sel ? dest1 : dest0), // Slot chosen by the issue FSM
    .dest_valid(even_sel ? dest_valid1 : dest_valid0),
    .lat(even_sel ? lat1 : lat0),
    .stage_recs(stage_recs_even), .wb_valid(wb_valid_even), .wb_dest(wb_dest_even));

  exec_pipe #(.pipe_depth(pipe_depth)) u_pipe_odd (
    .clk(clk), .rst(rst), .issue(issue_odd),
    .dest(odd_sel ? dest1 : dest0),
    .dest_valid(odd_sel ? dest_valid1 : dest_valid0),
    .lat(odd_sel ? lat1 : lat0),
    .stage_recs(stage_recs_odd), .wb_valid(wb_valid_odd), .wb_dest(wb_dest_odd));

endmodule

`default_nettype wire

// File: spu_pipe_pkg.sv
`default_nettype none

package spu_pipe_pkg;

  typedef enum logic {
    ISSUE_PAIR   = 1'b0, // Both slots pending
    ISSUE_SECOND = 1'b1  // Slot 0 gone, slot 1 waiting
  } issue_state_e;

  // In-flight record packed as {valid, dest, lat}
  localparam int rec_dest_w = spu_isa_pkg::reg_addr_w;
  localparam int rec_lat_w  = spu_isa_pkg::lat_w;
  localparam int rec_w      = 1 + rec_dest_w + rec_lat_w;

  localparam int rec_lat_lsb   = 0;
  localparam int rec_lat_msb   = rec_lat_lsb + rec_lat_w - 1;
  localparam int rec_dest_lsb  = rec_lat_msb + 1;
  localparam int rec_dest_msb  = rec_dest_lsb + rec_dest_w - 1;
  localparam int rec_valid_bit = rec_w - 1;

endpackage

`default_nettype wire

// File: tb_spu_issue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spu_issue;

  localparam int pipe_depth = 6;
  localparam int n_random   = 300;
  localparam int max_cycles = 4 * (200 + n_random * 4); // Directed part plus slow random pairs

  logic        clk;
  logic        rst;
  logic        pair_valid;
  logic [31:0] instr0;
  logic [31:0] instr1;
  logic        stall;
  logic        wb_valid_even;
  logic [6:0]  wb_dest_even;
  logic        wb_valid_odd;
  logic [6:0]  wb_dest_odd;

  integer     seed = 32'hb367_83f6;
  int         cycle_cnt = 0;
  logic       m_second;                      // Reference model, slot 0 already issued
  logic       m_valid [0:1][1:pipe_depth];   // Pipe 0 even, 1 odd
  logic [6:0] m_dest  [0:1][1:pipe_depth];
  int         m_lat   [0:1][1:pipe_depth];

  spu_issue_top #(.pipe_depth(pipe_depth)) u_dut (
    .clk(clk), .rst(rst), .pair_valid(pair_valid), .instr0(instr0), .instr1(instr1),
    .stall(stall), .wb_valid_even(wb_valid_even), .wb_dest_even(wb_dest_even),
    .wb_valid_odd(wb_valid_odd), .wb_dest_odd(wb_dest_odd));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", why);
  endtask

  function automatic logic [31:0] make_word(input logic [3:0] op, input int rt, input int ra,
                                            input int rb, input int rc);
    return {op, 7'(rt), 7'(ra), 7'(rb), 7'(rc)};
  endfunction

  function automatic logic [31:0] random_word();
    return make_word(4'($unsigned($random(seed)) % 9), $unsigned($random(seed)) % 4,
                     $unsigned($random(seed)) % 4, $unsigned($random(seed)) % 4,
                     $unsigned($random(seed)) % 4); // Four registers force collisions
  endfunction

  // Pipe 0 none, 1 even, 2 odd
  function automatic void decode_word(input logic [31:0] w, output int pipe,
                                      output logic [2:0] used, output logic [20:0] srcs,
                                      output logic wr, output logic [6:0] dst, output int lat);
    pipe = 0;
    used = 3'b000;
    wr   = 1'b0;
    lat  = 0;
    dst  = w[27:21];
    srcs = {w[6:0], w[13:7], w[20:14]};
    case (w[31:28])
      spu_isa_pkg::ADD, spu_isa_pkg::SHL, spu_isa_pkg::MPY, spu_isa_pkg::FMA: begin
        pipe = 1;
        wr   = 1'b1;
        used = (w[31:28] == spu_isa_pkg::FMA) ? 3'b111 : 3'b011;
        lat  = (w[31:28] == spu_isa_pkg::ADD) ? 2 : (w[31:28] == spu_isa_pkg::SHL) ? 4 : 6;
      end
      spu_isa_pkg::LOAD, spu_isa_pkg::SHUF: begin
        pipe = 2;
        wr   = 1'b1;
        used = (w[31:28] == spu_isa_pkg::LOAD) ? 3'b001 : 3'b111;
        lat  = (w[31:28] == spu_isa_pkg::LOAD) ? 6 : 4;
      end
      spu_isa_pkg::STORE: begin
        pipe       = 2;
        used       = 3'b011;
        srcs[13:7] = w[27:21]; // Store data read through rt
      end
      spu_isa_pkg::BR: begin
        pipe = 2;
        used = 3'b001;
      end
      default: begin
      end
    endcase
  endfunction

  function automatic logic reads_in_flight(input logic [2:0] used, input logic [20:0] srcs);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < 2; p++) begin
      for (int k = 1; k <= pipe_depth; k++) begin
        for (int i = 0; i < 3; i++) begin
          if (used[i] && m_valid[p][k] && srcs[i*7 +: 7] == m_dest[p][k] &&
              m_lat[p][k] > k + 1) begin
            hit = 1'b1;
          end
        end
      end
    end
    return hit;
  endfunction

  task automatic check_writeback(input int p, input logic got_valid, input logic [6:0] got_dest);
    logic exp_valid;
    logic dest_seen;
    exp_valid = 1'b0;
    dest_seen = 1'b0;
    for (int k = 1; k <= pipe_depth; k++) begin
      if (m_valid[p][k] && m_lat[p][k] == k) begin
        exp_valid = 1'b1;
        dest_seen = dest_seen | (got_dest == m_dest[p][k]); // Any finishing record may win
      end
    end
    assert (got_valid === exp_valid && (!exp_valid || dest_seen)) else begin
      $display("mismatch at %0t: wb_%s valid %b dest %0d, expected valid %b", $time,
               (p == 0) ? "even" : "odd", got_valid, got_dest, exp_valid);
      abort_run("writeback differs from the reference model");
    end
  endtask

  always @(posedge clk) begin : model_step
    int          pipe0, pipe1, lat0, lat1;
    logic [2:0]  used0, used1;
    logic [20:0] srcs0, srcs1;
    logic        wr0, wr1, raw0, raw1, dep, conflict, exp_stall, iss0, iss1;
    logic [6:0]  dst0, dst1;
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      abort_run("timeout, the stimulus did not complete in time");
    end
    if (rst) begin
      m_second = 1'b0;
      for (int p = 0; p < 2; p++) begin
        for (int k = 1; k <= pipe_depth; k++) begin
          m_valid[p][k] = 1'b0;
        end
      end
    end else begin
      decode_word(instr0, pipe0, used0, srcs0, wr0, dst0, lat0);
      decode_word(instr1, pipe1, used1, srcs1, wr1, dst1, lat1);
      raw0 = pipe0 != 0 && reads_in_flight(used0, srcs0);
      raw1 = pipe1 != 0 && reads_in_flight(used1, srcs1);
      dep  = wr0 && ((used1[0] && srcs1[6:0] == dst0) || (used1[1] && srcs1[13:7] == dst0) ||
                     (used1[2] && srcs1[20:14] == dst0));
      conflict = pipe0 != 0 && pipe1 != 0 &&
                 (pipe0 == pipe1 || (wr0 && wr1 && dst0 == dst1) || dep);
      exp_stall = 1'b0;
      iss0      = 1'b0;
      iss1      = 1'b0;
      if (pair_valid && !m_second) begin
        exp_stall = raw0 || conflict || raw1;
        iss0      = !raw0;
        iss1      = !exp_stall;
        m_second  = !raw0 && (conflict || raw1);
      end else if (pair_valid) begin
        exp_stall = raw1;
        iss1      = !raw1;
        m_second  = raw1;
      end
      assert (stall === exp_stall) else begin
        $display("mismatch at %0t: stall is %b, expected %b", $time, stall, exp_stall);
        abort_run("stall differs from the reference model");
      end
      check_writeback(0, wb_valid_even, wb_dest_even);
      check_writeback(1, wb_valid_odd, wb_dest_odd);
      for (int p = 0; p < 2; p++) begin
        for (int k = pipe_depth; k > 1; k--) begin
          m_valid[p][k] = m_valid[p][k-1];
          m_dest[p][k]  = m_dest[p][k-1];
          m_lat[p][k]   = m_lat[p][k-1];
        end
        m_valid[p][1] = 1'b0;
        if (iss0 && pipe0 == p + 1) begin
          m_valid[p][1] = wr0;
          m_dest[p][1]  = dst0;
          m_lat[p][1]   = lat0;
        end
        if (iss1 && pipe1 == p + 1) begin
          m_valid[p][1] = wr1;
          m_dest[p][1]  = dst1;
          m_lat[p][1]   = lat1;
        end
      end
    end
  end

  // Holds the pair until a rising edge sees stall low
  task automatic send_pair(input logic [31:0] w0, input logic [31:0] w1);
    logic held;
    @(negedge clk);
    pair_valid = 1'b1;
    instr0     = w0;
    instr1     = w1;
    held       = 1'b1;
    while (held) begin
      @(posedge clk);
      held = stall;
    end
  endtask

  task automatic idle(input int n);
    @(negedge clk);
    pair_valid = 1'b0; // Last pair stays on the bus
    repeat (n) @(posedge clk);
  endtask

  task automatic produce_consume(input logic [3:0] op);
    send_pair(make_word(op, 20, 1, 2, 3), make_word(spu_isa_pkg::NOP, 0, 0, 0, 0));
    send_pair(make_word(spu_isa_pkg::ADD, 21, 20, 4, 0),
              make_word(spu_isa_pkg::LOAD, 22, 20, 0, 0));
    idle(8);
  endtask

  initial begin
    rst        = 1'b1;
    pair_valid = 1'b0;
    instr0     = '0;
    instr1     = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle(3);
    send_pair(make_word(spu_isa_pkg::ADD, 10, 1, 2, 0), make_word(spu_isa_pkg::LOAD, 11, 3, 0, 0));
    idle(8);
    send_pair(make_word(spu_isa_pkg::ADD, 12, 1, 2, 0), make_word(spu_isa_pkg::SHL, 13, 3, 4, 0));
    send_pair(make_word(spu_isa_pkg::ADD, 15, 1, 2, 0), make_word(spu_isa_pkg::LOAD, 15, 3, 0, 0));
    idle(8);
    produce_consume(spu_isa_pkg::ADD);
    produce_consume(spu_isa_pkg::SHL);
    produce_consume(spu_isa_pkg::MPY);
    produce_consume(spu_isa_pkg::FMA);
    produce_consume(spu_isa_pkg::LOAD);
    produce_consume(spu_isa_pkg::SHUF);
    send_pair(make_word(spu_isa_pkg::MPY, 30, 1, 2, 0), make_word(spu_isa_pkg::LOAD, 31, 30, 0, 0));
    send_pair(make_word(spu_isa_pkg::STORE, 31, 30, 0, 0), make_word(spu_isa_pkg::BR, 0, 30, 0, 0));
    idle(8);
    for (int n = 0; n < n_random; n++) begin
      send_pair(random_word(), random_word());
      if ($unsigned($random(seed)) % 6 == 0) begin
        idle(1 + int'($unsigned($random(seed)) % 3));
      end
    end
    idle(10);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
